// ==== hdl/video_settings.svh ====
`ifndef VIDEO_SETTINGS_SVH
`define VIDEO_SETTINGS_SVH

// Bus widths
`define VIDEO_ADDR_W 32
`define VIDEO_DATA_W 32

// Line geometry, four index bytes per word
`define VIDEO_MAX_PITCH 640
`define VIDEO_LINE_WORDS (`VIDEO_MAX_PITCH / 4)

// Palette and raster
`define VIDEO_PAL_SIZE 256
`define VIDEO_COLOR_W 24
`define VIDEO_POS_W 11

// CPU address regions in bits 23:20
`define VIDEO_REGION_PAL 4'he
`define VIDEO_REGION_CTRL 4'hf

`endif

// ==== hdl/video_bus_pkg.sv ====
`include "video_settings.svh"

package video_bus_pkg;

	// ==========================================================
	// One request on the CPU bus or on memory port A
	// ==========================================================
	typedef struct packed {
		logic                     rw;
		logic [`VIDEO_ADDR_W-1:0] address;
		logic [`VIDEO_DATA_W-1:0] wdata;
	} bus_req_t;

	// Target of a CPU access
	typedef enum logic [1:0] {
		REGION_VRAM,
		REGION_PAL,
		REGION_CTRL
	} cpu_region_e;

	// Control register select, address bits 3:2
	typedef enum logic [1:0] {
		REG_OFFSET,
		REG_PITCH,
		REG_SKIP
	} ctrl_reg_e;

endpackage

// ==== hdl/video_disp_pkg.sv ====
`include "video_settings.svh"

package video_disp_pkg;

	// Display registers written by the CPU
	typedef struct packed {
		logic [31:0] read_offset;
		logic [31:0] pitch;
		logic [1:0]  skip;
	} disp_regs_t;

	// Raster position and blanking from the timing source
	typedef struct packed {
		logic                    hblank;
		logic                    vblank;
		logic [`VIDEO_POS_W-1:0] pos_x;
		logic [`VIDEO_POS_W-1:0] pos_y;
	} raster_t;

	// Port B line fetch
	typedef enum logic [1:0] {
		FETCH_IDLE,
		FETCH_REQ,
		FETCH_RELEASE
	} fetch_state_e;

endpackage

// ==== hdl/video_cpu_port.sv ====
`include "video_settings.svh"

module video_cpu_port
	import video_bus_pkg::*;
	import video_disp_pkg::*;
(
	input  logic                                i_clock,
	input  logic                                i_rst_n,
	input  logic                                i_cpu_req,
	input  bus_req_t                            i_cpu_bus,
	output logic                                o_cpu_ack,
	output logic [`VIDEO_DATA_W-1:0]            o_cpu_rdata,
	output logic                                o_vram_a_req,
	output bus_req_t                            o_vram_a_bus,
	input  logic                                i_vram_a_ack,
	input  logic [`VIDEO_DATA_W-1:0]            i_vram_a_rdata,
	output disp_regs_t                          o_regs,
	output logic                                o_pal_we,
	output logic [$clog2(`VIDEO_PAL_SIZE)-1:0]  o_pal_index,
	output logic [`VIDEO_COLOR_W-1:0]           o_pal_color
);

	localparam int PAL_IDX_W = $clog2(`VIDEO_PAL_SIZE);

	typedef enum logic [2:0] {
		CPU_IDLE,
		CPU_EXEC,
		CPU_MEM,
		CPU_ACK,
		CPU_HOLD
	} cpu_state_e;

	cpu_state_e                 state;
	cpu_region_e                region;
	ctrl_reg_e                  reg_sel;
	logic [3:0]                 region_code;
	logic [`VIDEO_DATA_W-1:0]   reg_rdata;

	assign region_code = i_cpu_bus.address[23:20];
	assign reg_sel = ctrl_reg_e'(i_cpu_bus.address[3:2]);

	// Register readback, skip zero extended
	always_comb begin
		case (reg_sel)
			REG_OFFSET: reg_rdata = o_regs.read_offset;
			REG_PITCH:  reg_rdata = o_regs.pitch;
			REG_SKIP:   reg_rdata = `VIDEO_DATA_W'(o_regs.skip);
			default:    reg_rdata = '0;
		endcase
	end

	// ==========================================================
	// Request FSM
	// ==========================================================
	always_ff @(posedge i_clock) begin
		if (!i_rst_n) begin
			state <= CPU_IDLE;
			region <= REGION_VRAM;
			o_cpu_ack <= 1'b0;
			o_vram_a_req <= 1'b0;
			o_pal_we <= 1'b0;
			o_regs <= '0;
		end else begin
			o_pal_we <= 1'b0;
			case (state)
				CPU_IDLE: begin
					// Port A must have finished its last handshake
					if (i_cpu_req && !i_vram_a_ack) begin
						if (region_code == `VIDEO_REGION_PAL) begin
							region <= REGION_PAL;
							o_pal_we <= i_cpu_bus.rw;
							o_pal_index <= i_cpu_bus.address[PAL_IDX_W+1:2];
							o_pal_color <= i_cpu_bus.wdata[`VIDEO_COLOR_W-1:0];
							state <= CPU_EXEC;
						end else if (region_code == `VIDEO_REGION_CTRL) begin
							region <= REGION_CTRL;
							state <= CPU_EXEC;
						end else begin
							region <= REGION_VRAM;
							o_vram_a_req <= 1'b1;
							o_vram_a_bus.rw <= i_cpu_bus.rw;
							o_vram_a_bus.address <= `VIDEO_ADDR_W'(i_cpu_bus.address[23:0]);
							o_vram_a_bus.wdata <= i_cpu_bus.wdata;
							state <= CPU_MEM;
						end
					end
				end
				CPU_EXEC: begin
					// Palette reads give zero
					o_cpu_rdata <= '0;
					if (region == REGION_CTRL) begin
						o_cpu_rdata <= reg_rdata;
						if (i_cpu_bus.rw) begin
							case (reg_sel)
								REG_OFFSET: o_regs.read_offset <= i_cpu_bus.wdata;
								REG_PITCH:  o_regs.pitch <= i_cpu_bus.wdata;
								REG_SKIP:   o_regs.skip <= i_cpu_bus.wdata[1:0];
								default:    o_regs <= o_regs;
							endcase
						end
					end
					state <= CPU_ACK;
				end
				CPU_MEM: begin
					if (i_vram_a_ack) begin
						o_vram_a_req <= 1'b0;
						o_cpu_rdata <= i_vram_a_rdata;
						o_cpu_ack <= 1'b1;
						state <= CPU_HOLD;
					end
				end
				CPU_ACK: begin
					o_cpu_ack <= 1'b1;
					state <= CPU_HOLD;
				end
				CPU_HOLD: begin
					if (!i_cpu_req) begin
						o_cpu_ack <= 1'b0;
						state <= CPU_IDLE;
					end
				end
				default: state <= CPU_IDLE;
			endcase
		end
	end

	// Port A fields held until the memory answers
	a_vram_a_stable: assert property (@(posedge i_clock) disable iff (!i_rst_n)
		o_vram_a_req && !i_vram_a_ack |=> $stable(o_vram_a_bus));

endmodule

// ==== hdl/video_line_fetch.sv ====
`include "video_settings.svh"

module video_line_fetch
	import video_disp_pkg::*;
(
	input  logic                                  i_clock,
	input  logic                                  i_rst_n,
	input  raster_t                               i_raster,
	input  disp_regs_t                            i_regs,
	output logic                                  o_vram_b_req,
	output logic [`VIDEO_ADDR_W-1:0]              o_vram_b_addr,
	input  logic                                  i_vram_b_ack,
	input  logic [`VIDEO_DATA_W-1:0]              i_vram_b_rdata,
	output logic                                  o_line_we,
	output logic [$clog2(`VIDEO_LINE_WORDS)-1:0]  o_line_index,
	output logic [`VIDEO_DATA_W-1:0]              o_line_data
);

	localparam int IDX_W = $clog2(`VIDEO_LINE_WORDS);
	localparam logic [IDX_W-1:0] MAX_WORDS = IDX_W'(`VIDEO_LINE_WORDS);

	fetch_state_e               state;
	logic                       hblank_q;
	logic                       vblank_q;
	logic                       vblank_fall;
	logic                       hblank_fall;
	logic                       line_start;
	logic                       line_odd;
	logic [`VIDEO_ADDR_W-1:0]   row_base;
	logic [`VIDEO_ADDR_W-1:0]   next_base;
	logic [31:0]                pitch_words;
	logic [IDX_W-1:0]           line_words;
	logic [IDX_W-1:0]           word_cnt;

	// Edges against the registered blank levels
	assign vblank_fall = vblank_q && !i_raster.vblank;
	assign hblank_fall = hblank_q && !i_raster.hblank && !i_raster.vblank;
	assign line_start = vblank_fall || hblank_fall;

	assign pitch_words = i_regs.pitch >> 2;
	assign line_words = (pitch_words > 32'(`VIDEO_LINE_WORDS)) ? MAX_WORDS
		: pitch_words[IDX_W-1:0];

	// Row base for the line about to be fetched
	always_comb begin
		if (vblank_fall) begin
			next_base = i_regs.read_offset;
		end else if (!i_regs.skip[1] || line_odd) begin
			next_base = row_base + i_regs.pitch;
		end else begin
			next_base = row_base;
		end
	end

	// ==========================================================
	// Port B burst, one four-phase cycle per word
	// ==========================================================
	always_ff @(posedge i_clock) begin
		if (!i_rst_n) begin
			state <= FETCH_IDLE;
			hblank_q <= 1'b0;
			vblank_q <= 1'b0;
			line_odd <= 1'b0;
			row_base <= '0;
			word_cnt <= '0;
			o_vram_b_req <= 1'b0;
			o_line_we <= 1'b0;
		end else begin
			hblank_q <= i_raster.hblank;
			vblank_q <= i_raster.vblank;
			o_line_we <= 1'b0;
			if (line_start) begin
				row_base <= next_base;
				line_odd <= vblank_fall ? 1'b0 : !line_odd;
			end
			case (state)
				FETCH_IDLE: begin
					if (line_start && line_words != '0) begin
						o_vram_b_req <= 1'b1;
						o_vram_b_addr <= next_base;
						word_cnt <= '0;
						state <= FETCH_REQ;
					end
				end
				FETCH_REQ: begin
					if (i_vram_b_ack) begin
						o_vram_b_req <= 1'b0;
						o_line_we <= 1'b1;
						o_line_index <= word_cnt;
						o_line_data <= i_vram_b_rdata;
						word_cnt <= word_cnt + 1'b1;
						state <= FETCH_RELEASE;
					end
				end
				FETCH_RELEASE: begin
					if (!i_vram_b_ack) begin
						if (word_cnt == line_words) begin
							state <= FETCH_IDLE;
						end else begin
							o_vram_b_req <= 1'b1;
							o_vram_b_addr <= o_vram_b_addr + `VIDEO_ADDR_W'(4);
							state <= FETCH_REQ;
						end
					end
				end
				default: state <= FETCH_IDLE;
			endcase
		end
	end

	a_line_index: assert property (@(posedge i_clock) disable iff (!i_rst_n)
		o_line_we |-> (o_line_index < MAX_WORDS));

endmodule

// ==== hdl/video_pixel_out.sv ====
`include "video_settings.svh"

module video_pixel_out
	import video_disp_pkg::*;
(
	input  logic                                  i_clock,
	input  raster_t                               i_raster,
	input  disp_regs_t                            i_regs,
	input  logic                                  i_pal_we,
	input  logic [$clog2(`VIDEO_PAL_SIZE)-1:0]    i_pal_index,
	input  logic [`VIDEO_COLOR_W-1:0]             i_pal_color,
	input  logic                                  i_line_we,
	input  logic [$clog2(`VIDEO_LINE_WORDS)-1:0]  i_line_index,
	input  logic [`VIDEO_DATA_W-1:0]              i_line_data,
	output logic [`VIDEO_COLOR_W-1:0]             o_pixel
);

	localparam int IDX_W = $clog2(`VIDEO_LINE_WORDS);
	localparam int PAL_IDX_W = $clog2(`VIDEO_PAL_SIZE);

	logic [`VIDEO_DATA_W-1:0]   line_mem [`VIDEO_LINE_WORDS];
	logic [`VIDEO_COLOR_W-1:0]  pal_mem [`VIDEO_PAL_SIZE];

	logic [`VIDEO_POS_W-3:0]    word_idx;
	logic [1:0]                 byte_sel;
	logic [1:0]                 byte_sel_q;
	logic [`VIDEO_DATA_W-1:0]   word_q;
	logic [PAL_IDX_W-1:0]       pal_addr;
	logic [`VIDEO_COLOR_W-1:0]  color_q;

	// Skip bit 0 doubles each pixel
	always_comb begin
		if (i_regs.skip[0]) begin
			word_idx = {1'b0, i_raster.pos_x[`VIDEO_POS_W-1:3]};
			byte_sel = i_raster.pos_x[2:1];
		end else begin
			word_idx = i_raster.pos_x[`VIDEO_POS_W-1:2];
			byte_sel = i_raster.pos_x[1:0];
		end
	end

	// Write ports
	always_ff @(posedge i_clock) begin
		if (i_line_we) begin
			line_mem[i_line_index] <= i_line_data;
		end
		if (i_pal_we) begin
			pal_mem[i_pal_index] <= i_pal_color;
		end
	end

	// ==========================================================
	// Three-stage lookup
	// ==========================================================
	always_ff @(posedge i_clock) begin
		if (word_idx < `VIDEO_LINE_WORDS) begin
			word_q <= line_mem[word_idx[IDX_W-1:0]];
		end else begin
			word_q <= '0;
		end
		byte_sel_q <= byte_sel;
	end

	assign pal_addr = word_q[byte_sel_q * 8 +: PAL_IDX_W];

	always_ff @(posedge i_clock) begin
		color_q <= pal_mem[pal_addr];
		o_pixel <= color_q;
	end

endmodule

// ==== hdl/video_controller.sv ====
`include "video_settings.svh"

module video_controller
	import video_bus_pkg::*;
	import video_disp_pkg::*;
(
	input  logic                        i_clock,
	input  logic                        i_rst_n,
	input  logic                        i_cpu_req,
	input  bus_req_t                    i_cpu_bus,
	output logic                        o_cpu_ack,
	output logic [`VIDEO_DATA_W-1:0]    o_cpu_rdata,
	output logic                        o_vram_a_req,
	output bus_req_t                    o_vram_a_bus,
	input  logic                        i_vram_a_ack,
	input  logic [`VIDEO_DATA_W-1:0]    i_vram_a_rdata,
	output logic                        o_vram_b_req,
	output logic [`VIDEO_ADDR_W-1:0]    o_vram_b_addr,
	input  logic                        i_vram_b_ack,
	input  logic [`VIDEO_DATA_W-1:0]    i_vram_b_rdata,
	input  raster_t                     i_raster,
	output logic [`VIDEO_COLOR_W-1:0]   o_pixel
);

	disp_regs_t                             regs;
	logic                                   pal_we;
	logic [$clog2(`VIDEO_PAL_SIZE)-1:0]     pal_index;
	logic [`VIDEO_COLOR_W-1:0]              pal_color;
	logic                                   line_we;
	logic [$clog2(`VIDEO_LINE_WORDS)-1:0]   line_index;
	logic [`VIDEO_DATA_W-1:0]               line_data;

	video_cpu_port cpu0 (
		.i_clock        (i_clock),
		.i_rst_n        (i_rst_n),
		.i_cpu_req      (i_cpu_req),
		.i_cpu_bus      (i_cpu_bus),
		.o_cpu_ack      (o_cpu_ack),
		.o_cpu_rdata    (o_cpu_rdata),
		.o_vram_a_req   (o_vram_a_req),
		.o_vram_a_bus   (o_vram_a_bus),
		.i_vram_a_ack   (i_vram_a_ack),
		.i_vram_a_rdata (i_vram_a_rdata),
		.o_regs         (regs),
		.o_pal_we       (pal_we),
		.o_pal_index    (pal_index),
		.o_pal_color    (pal_color)
	);

	video_line_fetch fetch0 (
		.i_clock        (i_clock),
		.i_rst_n        (i_rst_n),
		.i_raster       (i_raster),
		.i_regs         (regs),
		.o_vram_b_req   (o_vram_b_req),
		.o_vram_b_addr  (o_vram_b_addr),
		.i_vram_b_ack   (i_vram_b_ack),
		.i_vram_b_rdata (i_vram_b_rdata),
		.o_line_we      (line_we),
		.o_line_index   (line_index),
		.o_line_data    (line_data)
	);

	video_pixel_out pixel0 (
		.i_clock        (i_clock),
		.i_raster       (i_raster),
		.i_regs         (regs),
		.i_pal_we       (pal_we),
		.i_pal_index    (pal_index),
		.i_pal_color    (pal_color),
		.i_line_we      (line_we),
		.i_line_index   (line_index),
		.i_line_data    (line_data),
		.o_pixel        (o_pixel)
	);

endmodule

// ==== tb/tb_vram_model.sv ====
module tb_vram_model
	import video_bus_pkg::*;
(
	input  logic        i_clock,
	input  logic        i_rst_n,
	input  logic        i_a_req,
	input  bus_req_t    i_a_bus,
	output logic        o_a_ack,
	output logic [31:0] o_a_rdata,
	input  logic        i_b_req,
	input  logic [31:0] i_b_addr,
	output logic        o_b_ack,
	output logic [31:0] o_b_rdata
);

	timeunit 1ns;
	timeprecision 1ps;

	logic [31:0] mem [logic [31:0]];
	int          a_wait;
	int          b_wait;

	// Unwritten words hold the low address byte plus the byte position
	function automatic logic [31:0] read_word(input logic [31:0] a);
		if (mem.exists(a)) begin
			return mem[a];
		end
		return {a[7:0] + 8'd3, a[7:0] + 8'd2, a[7:0] + 8'd1, a[7:0]};
	endfunction

	// Port A, read and write
	always @(posedge i_clock) begin
		if (!i_rst_n) begin
			o_a_ack <= 1'b0;
			a_wait <= 0;
		end else if (o_a_ack) begin
			if (!i_a_req) begin
				o_a_ack <= 1'b0;
			end
		end else if (i_a_req) begin
			if (a_wait == 0) begin
				a_wait <= 1 + int'($urandom % 4);
			end else if (a_wait == 1) begin
				a_wait <= 0;
				o_a_ack <= 1'b1;
				if (i_a_bus.rw) begin
					mem[i_a_bus.address] = i_a_bus.wdata;
				end else begin
					o_a_rdata <= read_word(i_a_bus.address);
				end
			end else begin
				a_wait <= a_wait - 1;
			end
		end
	end

	// Port B, read only
	always @(posedge i_clock) begin
		if (!i_rst_n) begin
			o_b_ack <= 1'b0;
			b_wait <= 0;
		end else if (o_b_ack) begin
			if (!i_b_req) begin
				o_b_ack <= 1'b0;
			end
		end else if (i_b_req) begin
			if (b_wait == 0) begin
				b_wait <= 1 + int'($urandom % 4);
			end else if (b_wait == 1) begin
				b_wait <= 0;
				o_b_ack <= 1'b1;
				o_b_rdata <= read_word(i_b_addr);
			end else begin
				b_wait <= b_wait - 1;
			end
		end
	end

endmodule

// ==== tb/tb_video.sv ====
`include "video_settings.svh"

module tb_video
	import video_bus_pkg::*;
	import video_disp_pkg::*;
;

	timeunit 1ns;
	timeprecision 1ps;

	localparam logic [31:0] OFFSET = 32'h0000_1000;
	localparam logic [31:0] PITCH = 32'd16;

	logic                       clk;
	logic                       rst_n;
	logic                       cpu_req;
	bus_req_t                   cpu_bus;
	logic                       cpu_ack;
	logic [31:0]                cpu_rdata;
	logic                       a_req;
	bus_req_t                   a_bus;
	logic                       a_ack;
	logic [31:0]                a_rdata;
	logic                       b_req;
	logic [31:0]                b_addr;
	logic                       b_ack;
	logic [31:0]                b_rdata;
	raster_t                    raster;
	logic [`VIDEO_COLOR_W-1:0]  pixel;

	int          errors;
	int          timeouts;
	logic        rd_chk;
	logic [31:0] exp_rdata;
	bus_req_t    exp_a_bus;
	logic        frame_on;
	logic        line_start;
	logic        line_chk;
	logic        pix_chk;
	logic        dbl;
	logic [31:0] line_base;
	logic [31:0] words_seen;
	logic [31:0] exp_b_addr;
	logic        b_req_q;
	logic [23:0] exp_pix;
	logic [2:0]  pix_chk_q;
	logic [23:0] exp_pix_q [3];

	video_controller dut0 (
		.i_clock(clk), .i_rst_n(rst_n),
		.i_cpu_req(cpu_req), .i_cpu_bus(cpu_bus),
		.o_cpu_ack(cpu_ack), .o_cpu_rdata(cpu_rdata),
		.o_vram_a_req(a_req), .o_vram_a_bus(a_bus),
		.i_vram_a_ack(a_ack), .i_vram_a_rdata(a_rdata),
		.o_vram_b_req(b_req), .o_vram_b_addr(b_addr),
		.i_vram_b_ack(b_ack), .i_vram_b_rdata(b_rdata),
		.i_raster(raster), .o_pixel(pixel)
	);

	tb_vram_model vram0 (
		.i_clock(clk), .i_rst_n(rst_n),
		.i_a_req(a_req), .i_a_bus(a_bus), .o_a_ack(a_ack), .o_a_rdata(a_rdata),
		.i_b_req(b_req), .i_b_addr(b_addr), .o_b_ack(b_ack), .o_b_rdata(b_rdata)
	);

	function automatic logic [23:0] pal_color(input logic [7:0] i);
		return {i ^ 8'h3c, ~i, i};
	endfunction

	// Colour from the memory fill pattern of the current line
	function automatic logic [23:0] pixel_color(input logic [10:0] x, input logic [31:0] base,
		input logic double);
		logic [31:0] wa;
		logic [1:0]  bs;
		if (double) begin
			wa = base + 32'(x >> 3) * 4;
			bs = x[2:1];
		end else begin
			wa = base + 32'(x >> 2) * 4;
			bs = x[1:0];
		end
		return pal_color(wa[7:0] + 8'(bs));
	endfunction

	// Count one failed check and report it
	task automatic log_error(input string msg);
		errors++;
		$display("%s", msg);
	endtask

	assign exp_pix = pixel_color(raster.pos_x, line_base, dbl);
	assign exp_b_addr = line_base + words_seen * 4;

	// Port A carries the CPU request with the address cut to 24 bits
	assign exp_a_bus = {cpu_bus.rw, 8'h00, cpu_bus.address[23:0], cpu_bus.wdata};

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// Port B word counter per line
	always @(posedge clk) begin
		b_req_q <= b_req;
		if (line_start) begin
			words_seen <= 0;
		end else if (b_req && !b_req_q) begin
			words_seen <= words_seen + 1;
		end
	end

	// Expected pixel delayed to the output
	always @(posedge clk) begin
		pix_chk_q <= {pix_chk_q[1:0], pix_chk};
		exp_pix_q[0] <= exp_pix;
		exp_pix_q[1] <= exp_pix_q[0];
		exp_pix_q[2] <= exp_pix_q[1];
	end

	// ============================================================
	// Checks
	// ============================================================
	a_ack_rise: assert property (@(posedge clk) disable iff (!rst_n) $rose(cpu_ack) |-> cpu_req)
		else log_error("CPU ack rose without a request");
	a_ack_fall: assert property (@(posedge clk) disable iff (!rst_n)
		$fell(cpu_ack) |-> !$past(cpu_req))
		else log_error("CPU ack fell before the request was released");
	a_porta_req: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(a_req) |-> $past(cpu_req))
		else log_error("Port A request without a CPU request");
	a_portb_req: assert property (@(posedge clk) disable iff (!rst_n) $rose(b_req) |-> frame_on)
		else log_error("Port B request before any frame");
	a_porta_bus: assert property (@(posedge clk) disable iff (!rst_n) a_req |-> a_bus == exp_a_bus)
		else log_error($sformatf("ERROR o_vram_a_bus: got %h expected %h", $sampled(a_bus),
			$sampled(exp_a_bus)));
	a_cpu_rdata: assert property (@(posedge clk) rd_chk |-> cpu_rdata == exp_rdata)
		else log_error($sformatf("ERROR o_cpu_rdata: got %h expected %h", $sampled(cpu_rdata),
			$sampled(exp_rdata)));
	a_b_addr: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(b_req) |-> b_addr == exp_b_addr)
		else log_error($sformatf("ERROR o_vram_b_addr: got %h expected %h", $sampled(b_addr),
			$sampled(exp_b_addr)));
	a_b_count: assert property (@(posedge clk) line_chk |-> words_seen == PITCH / 4)
		else log_error($sformatf("ERROR words_seen: got %h expected %h", $sampled(words_seen),
			PITCH / 4));
	a_pixel: assert property (@(posedge clk) pix_chk_q[2] |-> pixel == exp_pix_q[2])
		else log_error($sformatf("ERROR o_pixel: got %h expected %h", $sampled(pixel),
			$sampled(exp_pix_q[2])));

	task automatic cpu_access(input logic rw, input logic [31:0] addr, input logic [31:0] wdata,
		input logic check, input logic [31:0] expect_data);
		int n;
		@(posedge clk);
		cpu_req <= 1'b1;
		cpu_bus <= '{rw: rw, address: addr, wdata: wdata};
		for (n = 0; n < 100; n++) begin
			@(posedge clk);
			if (cpu_ack) break;
		end
		if (n == 100) begin
			timeouts++;
			$display("Timeout waiting for CPU ack at address %h", addr);
		end
		cpu_req <= 1'b0;
		rd_chk <= check;
		exp_rdata <= expect_data;
		for (n = 0; n < 100; n++) begin
			@(posedge clk);
			rd_chk <= 1'b0;
			if (!cpu_ack) break;
		end
		if (n == 100) begin
			timeouts++;
			$display("Timeout waiting for CPU ack to fall");
		end
	endtask

	task automatic run_frame(input logic [1:0] skip, input int lines);
		int line;
		int n;
		int x;
		@(posedge clk);
		raster.vblank <= 1'b1;
		raster.hblank <= 1'b0;
		frame_on <= 1'b1;
		dbl <= skip[0];
		repeat (4) @(posedge clk);
		for (line = 0; line < lines; line++) begin
			if (line == 0) begin
				raster.vblank <= 1'b0;
			end else begin
				raster.hblank <= 1'b1;
				repeat (3) @(posedge clk);
				raster.hblank <= 1'b0;
			end
			line_base <= OFFSET + PITCH * 32'(skip[1] ? line / 2 : line);
			line_start <= 1'b1;
			@(posedge clk);
			line_start <= 1'b0;
			// Fetch must finish before the active pixels
			for (n = 0; n < 500; n++) begin
				@(posedge clk);
				if (words_seen == PITCH / 4 && !b_req && !b_ack) break;
			end
			if (n == 500) begin
				timeouts++;
				$display("Timeout waiting for line %0d fetch", line);
			end
			repeat (2) @(posedge clk);
			line_chk <= 1'b1;
			@(posedge clk);
			line_chk <= 1'b0;
			for (x = 0; x < PITCH * (skip[0] ? 2 : 1); x++) begin
				raster.pos_x <= 11'(x);
				pix_chk <= 1'b1;
				@(posedge clk);
			end
			pix_chk <= 1'b0;
			repeat (4) @(posedge clk);
		end
		raster.vblank <= 1'b1;
	endtask

	initial begin
		logic [31:0] data;
		int i;
		void'($urandom(32'h6656_8f4e));
		errors = 0;
		timeouts = 0;
		rst_n = 1'b0;
		cpu_req = 1'b0;
		cpu_bus = '0;
		raster = '{hblank: 1'b0, vblank: 1'b1, pos_x: '0, pos_y: '0};
		rd_chk = 1'b0;
		exp_rdata = '0;
		frame_on = 1'b0;
		line_start = 1'b0;
		line_chk = 1'b0;
		pix_chk = 1'b0;
		pix_chk_q = '0;
		dbl = 1'b0;
		line_base = OFFSET;
		words_seen = '0;
		repeat (10) @(posedge clk);
		rst_n <= 1'b1;
		repeat (5) @(posedge clk);

		cpu_access(1'b1, 32'h00F0_0000, OFFSET, 1'b0, '0);
		cpu_access(1'b1, 32'h00F0_0004, PITCH, 1'b0, '0);
		cpu_access(1'b1, 32'h00F0_0008, 32'h0000_0007, 1'b0, '0);
		cpu_access(1'b0, 32'h00F0_0000, '0, 1'b1, OFFSET);
		cpu_access(1'b0, 32'h00F0_0004, '0, 1'b1, PITCH);
		cpu_access(1'b0, 32'h00F0_0008, '0, 1'b1, 32'h0000_0003);

		// Upper address byte is dropped on port A
		for (i = 0; i < 6; i++) begin
			data = $urandom;
			cpu_access(1'b1, {8'(8'h55 + i), 24'h012340 + 24'(i * 4)}, data, 1'b0, '0);
			cpu_access(1'b0, {8'h00, 24'h012340 + 24'(i * 4)}, '0, 1'b1, data);
		end

		for (i = 0; i < 256; i++) begin
			cpu_access(1'b1, 32'h00E0_0000 | 32'(i * 4), 32'(pal_color(8'(i))), 1'b0, '0);
		end

		cpu_access(1'b1, 32'h00F0_0008, 32'h0, 1'b0, '0);
		run_frame(2'b00, 3);
		cpu_access(1'b1, 32'h00F0_0008, 32'h3, 1'b0, '0);
		run_frame(2'b11, 4);
		repeat (5) @(posedge clk);

		$display("Errors: %0d check failures, %0d timeouts", errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

// ==== src.f ====
+incdir+hdl
hdl/video_bus_pkg.sv
hdl/video_disp_pkg.sv
hdl/video_cpu_port.sv
hdl/video_line_fetch.sv
hdl/video_pixel_out.sv
hdl/video_controller.sv
tb/tb_vram_model.sv
tb/tb_video.sv

// ==== run.sh ====
#!/bin/bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f src.f --top-module tb_video \
	-o tb_video_sim || exit 1
out="$(./obj_dir/tb_video_sim)"
echo "$out"
echo "$out" | grep -q "TESTS PASSED" && exit 0 || exit 1
